//--- soc_core.f
+incdir+dv
hw/bus_pkg.sv
hw/misc_pkg.sv
hw/dbg_loader.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/misc_regs.sv
hw/reload_seq.sv
hw/soc_core.sv
dv/soc_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module soc_core_tb -f soc_core.f \
	-o soc_core_sim \
	&& ./obj_dir/soc_core_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
	|| { echo "simulation did not pass"; exit 1; }

//--- dv/tb_stimulus.svh
// columns are kind, address, data, strobe and expected
// dbg rows carry sel in address bit 0 and btn rows carry the button value in data
task automatic load_rows();
	// led write and read back
	add_row(ROW_CPU_WR, 32'h2000_0000, 32'h1234_c35a, 4'hf, 32'h0);
	add_row(ROW_CHK_LED, 32'h0, 32'h0, 4'h0, 32'h0000_c35a);
	add_row(ROW_CPU_RD, 32'h2000_0000, 32'h0, 4'h0, 32'h0000_c35a);
	// buttons read inverted, version, master number, unlisted index
	add_row(ROW_BTN_SET, 32'h0, 32'h0000_003c, 4'h0, 32'h0);
	add_row(ROW_CPU_RD, 32'h2000_0004, 32'h0, 4'h0, 32'h0000_00c3);
	add_row(ROW_CPU_RD, 32'h2000_0008, 32'h0, 4'h0, 32'h0000_8000);
	add_row(ROW_CPU_RD, 32'h2000_000c, 32'h0, 4'h0, 32'h0000_0000);
	add_row(ROW_CPU_RD, 32'h2000_0014, 32'h0, 4'h0, 32'h0000_0000);
	// external memory
	add_row(ROW_CPU_WR, 32'h4000_0010, 32'hcafe_0001, 4'hf, 32'h0);
	add_row(ROW_EXP_MEM_WR, 32'h4000_0010, 32'hcafe_0001, 4'hf, 32'h0);
	add_row(ROW_CPU_WR, 32'h4000_0024, 32'h5566_7788, 4'h3, 32'h0);
	add_row(ROW_EXP_MEM_WR, 32'h4000_0024, 32'h5566_7788, 4'h3, 32'h0);
	add_row(ROW_CPU_RD, 32'h4000_0010, 32'h0, 4'h0, 32'hcafe_0001);
	// undecoded regions
	add_row(ROW_CPU_RD, 32'h0000_0100, 32'h0, 4'h0, 32'hdead_beef);
	add_row(ROW_CPU_RD, 32'h5000_0000, 32'h0, 4'h0, 32'hdead_beef);
	add_row(ROW_CPU_WR, 32'h0000_0040, 32'h0bad_0bad, 4'hf, 32'h0);
	// debug loader gets one address then two data words
	add_row(ROW_DBG_STROBE, 32'h1, 32'h4000_0080, 4'h0, 32'h0);
	add_row(ROW_DBG_STROBE, 32'h0, 32'h1111_2222, 4'h0, 32'h0);
	add_row(ROW_DBG_STROBE, 32'h0, 32'h3333_4444, 4'h0, 32'h0);
	add_row(ROW_EXP_MEM_WR, 32'h4000_0080, 32'h1111_2222, 4'hf, 32'h0);
	add_row(ROW_EXP_MEM_WR, 32'h4000_0084, 32'h3333_4444, 4'hf, 32'h0);
	add_row(ROW_CPU_RD, 32'h4000_0084, 32'h0, 4'h0, 32'h3333_4444);
	// plain flash select write and then one with the reload key
	add_row(ROW_FSEL_WR, 32'h2000_002c, 32'h0000_0001, 4'h1, 32'h1);
	add_row(ROW_FSEL_WR, 32'h2000_002c, 32'h00d0_f1a5, 4'h1, 32'h0);
endtask

//--- dv/soc_core_tb.sv
`timescale 1ns/100ps

// testbench for soc_core
// the CPU side is driven from a table and the external memory is modeled here
module soc_core_tb;

	typedef enum logic [2:0] {
		ROW_CPU_WR,
		ROW_CPU_RD,
		ROW_DBG_STROBE,
		ROW_BTN_SET,
		ROW_EXP_MEM_WR,
		ROW_CHK_LED,
		ROW_FSEL_WR
	} row_kind_t;

	typedef struct packed {
		row_kind_t          kind;
		bus_pkg::bus_word_t addr;
		bus_pkg::bus_word_t data;
		bus_pkg::bus_strb_t strb;
		bus_pkg::bus_word_t exp;
	} row_t;

	logic clk48m;
	logic rst;
	bus_pkg::bus_req_t cpu_req;
	bus_pkg::bus_rsp_t cpu_rsp;
	bus_pkg::bus_req_t mem_req;
	bus_pkg::bus_rsp_t mem_rsp;
	logic dbgreg_strobe;
	logic dbgreg_sel;
	bus_pkg::bus_word_t dbgreg_in;
	misc_pkg::btn_t btn;
	misc_pkg::led_t led;
	logic fsel_d;
	logic fsel_c;
	logic programn;
	logic bus_irq;

	row_t rows[$];
	bus_pkg::bus_req_t wr_log[$];
	bus_pkg::bus_word_t mem [64];
	bus_pkg::bus_rsp_t rsp_next;
	logic mem_pending;
	int mem_wait;
	int byte_i;
	int word_i;
	int row_i;
	int seed;
	int cycle_cnt;
	int cycle_limit;

	soc_core #(
		.SOC_VERSION(32'h8000),
		.DBG_FIFO_DEPTH(32)
	) i_dut (
		.clk48m(clk48m),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.dbgreg_strobe(dbgreg_strobe),
		.dbgreg_sel(dbgreg_sel),
		.dbgreg_in(dbgreg_in),
		.btn(btn),
		.led(led),
		.fsel_d(fsel_d),
		.fsel_c(fsel_c),
		.programn(programn),
		.bus_irq(bus_irq)
	);

	always #50 clk48m = ~clk48m;

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input bus_pkg::bus_word_t got, input bus_pkg::bus_word_t exp,
		input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0t: %s is 0x%08h, expected 0x%08h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_led(input misc_pkg::led_t got, input misc_pkg::led_t exp,
		input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0t: %s is 0x%04h, expected 0x%04h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// initial word is built from the swapped address halves
	function automatic bus_pkg::bus_word_t fill_word(input bus_pkg::bus_word_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6b1d_e2c7;
	endfunction

	// memory model decides at the rising edge and drives its answer at the falling edge
	always @(posedge clk48m) begin
		if (rst) begin
			rsp_next = '0;
			mem_pending = 1'b0;
		end else if (mem_rsp.ready) begin
			if (mem_req.wstrb != 4'h0) begin
				for (byte_i = 0; byte_i < 4; byte_i++) begin
					if (mem_req.wstrb[byte_i]) begin
						mem[mem_req.addr[7:2]][byte_i*8 +: 8] = mem_req.wdata[byte_i*8 +: 8];
					end
				end
				wr_log.push_back(mem_req);
			end
			rsp_next = '0;
			mem_pending = 1'b0;
		end else if (mem_req.valid) begin
			if (!mem_pending) begin
				// 0 to 3 idle cycles before ready
				mem_wait = $unsigned($random(seed)) % 4;
				mem_pending = 1'b1;
			end
			if (mem_wait == 0) begin
				rsp_next.ready = 1'b1;
				rsp_next.rdata = mem[mem_req.addr[7:2]];
			end else begin
				mem_wait = mem_wait - 1;
			end
		end
	end

	always @(negedge clk48m) begin
		mem_rsp = rsp_next;
	end

	always @(posedge clk48m) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			stop_with_failure($sformatf(
				"timeout, the table did not finish within %0d clock cycles",
				cycle_limit));
		end
	end

	task automatic add_row(input row_kind_t kind, input bus_pkg::bus_word_t addr,
		input bus_pkg::bus_word_t data, input bus_pkg::bus_strb_t strb,
		input bus_pkg::bus_word_t exp);
		rows.push_back('{kind: kind, addr: addr, data: data, strb: strb, exp: exp});
	endtask

	`include "tb_stimulus.svh"

	// called at a falling edge and returns at the falling edge after the ready edge
	task automatic bus_access(input bus_pkg::bus_word_t addr, input bus_pkg::bus_word_t wdata,
		input bus_pkg::bus_strb_t wstrb, output bus_pkg::bus_word_t rdata);
		cpu_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
		@(posedge clk48m);
		while (!cpu_rsp.ready) begin
			@(posedge clk48m);
		end
		rdata = cpu_rsp.rdata;
		@(negedge clk48m);
		cpu_req = '0;
	endtask

	// error pulse only for regions other than misc and memory
	task automatic check_irq_pulse(input bus_pkg::bus_word_t addr);
		logic err_exp;
		err_exp = (addr[31:28] != bus_pkg::REGION_MISC) &&
			(addr[31:28] != bus_pkg::REGION_MEM);
		check_bit(bus_irq, err_exp, "bus_irq in the cycle after completion");
		@(negedge clk48m);
		check_bit(bus_irq, 1'b0, "bus_irq two cycles after completion");
	endtask

	task automatic run_row(input row_t row);
		bus_pkg::bus_word_t rdata;
		bus_pkg::bus_req_t wr;
		int k;
		int c_high;
		int c_rises;
		logic c_prev;
		logic low_seen;
		case (row.kind)
			ROW_CPU_WR: begin
				bus_access(row.addr, row.data, row.strb, rdata);
				check_irq_pulse(row.addr);
			end
			ROW_CPU_RD: begin
				bus_access(row.addr, '0, 4'h0, rdata);
				check_word(rdata, row.exp, $sformatf("read of 0x%08h", row.addr));
				check_irq_pulse(row.addr);
			end
			ROW_DBG_STROBE: begin
				dbgreg_strobe = 1'b1;
				dbgreg_sel = row.addr[0];
				dbgreg_in = row.data;
				@(negedge clk48m);
				dbgreg_strobe = 1'b0;
			end
			ROW_BTN_SET: begin
				btn = row.data[7:0];
			end
			ROW_EXP_MEM_WR: begin
				while (wr_log.size() == 0) begin
					@(negedge clk48m);
				end
				wr = wr_log.pop_front();
				check_word(wr.addr, row.addr, "memory write address");
				check_word(wr.wdata, row.data, "memory write data");
				check_word({28'h0, wr.wstrb}, {28'h0, row.strb}, "memory write strobe");
			end
			ROW_CHK_LED: begin
				check_led(led, row.exp[15:0], "led");
			end
			ROW_FSEL_WR: begin
				bus_access(row.addr, row.data, row.strb, rdata);
				check_bit(fsel_d, row.data[0], "fsel_d after flash select write");
				c_high = 0;
				c_rises = 0;
				c_prev = 1'b0;
				low_seen = 1'b0;
				for (k = 0; k < 10; k++) begin
					if (k != 0) begin
						@(negedge clk48m);
					end
					if (fsel_c && !c_prev) begin
						c_rises++;
					end
					if (fsel_c) begin
						c_high++;
					end
					c_prev = fsel_c;
					if (low_seen) begin
						check_bit(programn, 1'b0, "programn after it fell");
					end
					if (!programn) begin
						low_seen = 1'b1;
					end
				end
				check_word(c_high, 32'd3, "fsel_c high cycle count");
				check_word(c_rises, 32'd1, "fsel_c pulse count");
				check_bit(programn, row.exp[0], "programn at the end of the sequence");
			end
			default: begin
				stop_with_failure("the stimulus table holds a row of unknown kind");
			end
		endcase
	endtask

	initial begin
		clk48m = 1'b0;
		rst = 1'b1;
		cpu_req = '0;
		mem_rsp = '0;
		rsp_next = '0;
		mem_pending = 1'b0;
		mem_wait = 0;
		dbgreg_strobe = 1'b0;
		dbgreg_sel = 1'b0;
		dbgreg_in = '0;
		btn = '0;
		seed = 32'hc3a523cc;
		cycle_cnt = 0;
		for (word_i = 0; word_i < 64; word_i++) begin
			mem[word_i] = fill_word({bus_pkg::REGION_MEM, 20'h0, word_i[5:0], 2'b00});
		end
		load_rows();
		cycle_limit = rows.size() * 40 + 200;
		repeat (8) @(posedge clk48m);
		@(negedge clk48m);
		check_led(led, 16'h0, "led in reset");
		check_bit(fsel_d, 1'b0, "fsel_d in reset");
		check_bit(fsel_c, 1'b0, "fsel_c in reset");
		check_bit(programn, 1'b1, "programn in reset");
		check_bit(bus_irq, 1'b0, "bus_irq in reset");
		check_bit(mem_req.valid, 1'b0, "mem_req valid in reset");
		check_bit(cpu_rsp.ready, 1'b0, "cpu_rsp ready in reset");
		rst = 1'b0;
		for (row_i = 0; row_i < rows.size(); row_i++) begin
			run_row(rows[row_i]);
		end
		check_word(wr_log.size(), 32'd0, "count of unexpected memory writes");
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- hw/soc_core.sv
`timescale 1ns/100ps

// bus fabric and system control
module soc_core #(
	parameter bus_pkg::bus_word_t SOC_VERSION = 32'h0,
	parameter int DBG_FIFO_DEPTH = 32
) (
	input  logic               clk48m,
	input  logic               rst,
	input  bus_pkg::bus_req_t  cpu_req,
	output bus_pkg::bus_rsp_t  cpu_rsp,
	output bus_pkg::bus_req_t  mem_req,
	input  bus_pkg::bus_rsp_t  mem_rsp,
	input  logic               dbgreg_strobe,
	input  logic               dbgreg_sel,
	input  bus_pkg::bus_word_t dbgreg_in,
	input  misc_pkg::btn_t     btn,
	output misc_pkg::led_t     led,
	output logic               fsel_d,
	output logic               fsel_c,
	output logic               programn,
	output logic               bus_irq
);

	bus_pkg::bus_req_t dbg_req;
	bus_pkg::bus_rsp_t dbg_rsp;
	bus_pkg::bus_req_t slv_req;
	bus_pkg::bus_rsp_t slv_rsp;
	bus_pkg::master_idx_t curr_master;
	bus_pkg::bus_word_t misc_rdata;
	logic misc_sel;
	logic fsel_strobe;
	logic reload_req;

	dbg_loader #(
		.DBG_FIFO_DEPTH(DBG_FIFO_DEPTH)
	) i_dbg_loader (
		.clk48m(clk48m),
		.rst(rst),
		.dbgreg_strobe(dbgreg_strobe),
		.dbgreg_sel(dbgreg_sel),
		.dbgreg_in(dbgreg_in),
		.req(dbg_req),
		.rsp(dbg_rsp)
	);

	bus_arbiter i_bus_arbiter (
		.clk48m(clk48m),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.dbg_req(dbg_req),
		.dbg_rsp(dbg_rsp),
		.slv_req(slv_req),
		.slv_rsp(slv_rsp),
		.curr_master(curr_master)
	);

	bus_decoder i_bus_decoder (
		.clk48m(clk48m),
		.rst(rst),
		.req(slv_req),
		.rsp(slv_rsp),
		.misc_sel(misc_sel),
		.misc_rdata(misc_rdata),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.bus_irq(bus_irq)
	);

	misc_regs #(
		.SOC_VERSION(SOC_VERSION)
	) i_misc_regs (
		.clk48m(clk48m),
		.rst(rst),
		.sel(misc_sel),
		.req(slv_req),
		.rdata(misc_rdata),
		.btn(btn),
		.curr_master(curr_master),
		.led(led),
		.fsel_d(fsel_d),
		.fsel_strobe(fsel_strobe),
		.reload_req(reload_req)
	);

	reload_seq i_reload_seq (
		.clk48m(clk48m),
		.rst(rst),
		.fsel_strobe(fsel_strobe),
		.reload_req(reload_req),
		.fsel_c(fsel_c),
		.programn(programn)
	);

endmodule

//--- hw/reload_seq.sv
`timescale 1ns/100ps

// flash select clocking and FPGA reload
// the select flop gets a few cycles to settle before programn drops
module reload_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_strobe,
	input  logic reload_req,
	output logic fsel_c,
	output logic programn
);

	misc_pkg::settle_cnt_t settle_cnt;
	logic reload_flag;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			settle_cnt <= '0;
			reload_flag <= 1'b0;
		end else if (fsel_strobe) begin
			settle_cnt <= misc_pkg::SETTLE_START;
		end else if (settle_cnt != 3'd0) begin
			settle_cnt <= settle_cnt - 3'd1;
			if (settle_cnt == 3'd1 && reload_req) begin
				reload_flag <= 1'b1;
			end
		end
	end

	// clock pulse sits in the middle of the settle window
	assign fsel_c = (settle_cnt <= misc_pkg::FSEL_C_HI) &&
		(settle_cnt >= misc_pkg::FSEL_C_LO);
	assign programn = !reload_flag;

	// once programn is low the armed request must stay up until reset
	a_programn_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn |=> (!programn && reload_req))
		else $error("programn rose or the reload request dropped after a reload");

endmodule

//--- hw/misc_regs.sv
`timescale 1ns/100ps

// misc register block in region 2
module misc_regs #(
	parameter bus_pkg::bus_word_t SOC_VERSION = 32'h0
) (
	input  logic                 clk48m,
	input  logic                 rst,
	input  logic                 sel,
	input  bus_pkg::bus_req_t    req,
	output bus_pkg::bus_word_t   rdata,
	input  misc_pkg::btn_t       btn,
	input  bus_pkg::master_idx_t curr_master,
	output misc_pkg::led_t       led,
	output logic                 fsel_d,
	output logic                 fsel_strobe,
	output logic                 reload_req
);

	misc_pkg::misc_reg_t idx;
	logic wr;

	assign idx = req.addr[5:2];

	// misc accesses complete in the cycle they are selected
	assign wr = sel && req.wstrb[0];

	always_comb begin
		case (idx)
			misc_pkg::MISC_LED: begin
				rdata = {16'h0, led};
			end
			misc_pkg::MISC_BTN: begin
				// buttons are active low on the board
				rdata = {24'h0, ~btn};
			end
			misc_pkg::MISC_SOC_VER: begin
				rdata = SOC_VERSION;
			end
			misc_pkg::MISC_CPU_NO: begin
				rdata = {31'h0, curr_master};
			end
			misc_pkg::MISC_FLASH_SEL: begin
				rdata = {31'h0, fsel_d};
			end
			default: begin
				rdata = '0;
			end
		endcase
	end

	// starts the settle counter on the same edge that updates fsel_d
	assign fsel_strobe = wr && (idx == misc_pkg::MISC_FLASH_SEL);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
			fsel_d <= 1'b0;
			reload_req <= 1'b0;
		end else if (wr) begin
			if (idx == misc_pkg::MISC_LED) begin
				led <= req.wdata[15:0];
			end
			if (fsel_strobe) begin
				fsel_d <= req.wdata[0];
				// key stays armed until reset
				if (req.wdata[23:0] == misc_pkg::RELOAD_KEY) begin
					reload_req <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/bus_decoder.sv
`timescale 1ns/100ps

// address decode for the shared slave side
module bus_decoder (
	input  logic               clk48m,
	input  logic               rst,
	input  bus_pkg::bus_req_t  req,
	output bus_pkg::bus_rsp_t  rsp,
	output logic               misc_sel,
	input  bus_pkg::bus_word_t misc_rdata,
	output bus_pkg::bus_req_t  mem_req,
	input  bus_pkg::bus_rsp_t  mem_rsp,
	output logic               bus_irq
);

	bus_pkg::region_t region;
	logic misc_hit;
	logic mem_hit;
	logic bus_err;

	assign region = req.addr[31:28];
	assign misc_hit = (region == bus_pkg::REGION_MISC);
	assign mem_hit = (region == bus_pkg::REGION_MEM);

	// anything outside misc and memory is an error
	assign misc_sel = req.valid && misc_hit;
	assign bus_err = req.valid && !misc_hit && !mem_hit;

	always_comb begin
		mem_req = req;
		mem_req.valid = req.valid && mem_hit;
	end

	always_comb begin
		if (misc_hit) begin
			rsp.rdata = misc_rdata;
		end else if (mem_hit) begin
			rsp.rdata = mem_rsp.rdata;
		end else begin
			rsp.rdata = bus_pkg::BUS_ERR_WORD;
		end
	end

	// misc and errors answer in the same cycle, memory whenever it is done
	assign rsp.ready = misc_sel || bus_err || (mem_hit && mem_rsp.ready);

	// one cycle pulse after each error completes
	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_irq <= 1'b0;
		end else begin
			bus_irq <= bus_err;
		end
	end

	a_mem_ready_selected: assert property (@(posedge clk48m) disable iff (rst)
		mem_rsp.ready |-> mem_req.valid)
		else $error("memory ready while memory not selected");

endmodule

//--- hw/bus_arbiter.sv
`timescale 1ns/100ps

// two master arbiter, CPU has priority when nothing is in flight
module bus_arbiter (
	input  logic                 clk48m,
	input  logic                 rst,
	input  bus_pkg::bus_req_t    cpu_req,
	output bus_pkg::bus_rsp_t    cpu_rsp,
	input  bus_pkg::bus_req_t    dbg_req,
	output bus_pkg::bus_rsp_t    dbg_rsp,
	output bus_pkg::bus_req_t    slv_req,
	input  bus_pkg::bus_rsp_t    slv_rsp,
	output bus_pkg::master_idx_t curr_master
);

	logic locked;
	bus_pkg::master_idx_t grant_q;
	bus_pkg::master_idx_t grant;

	always_comb begin
		if (locked) begin
			grant = grant_q;
		end else if (cpu_req.valid) begin
			grant = bus_pkg::MASTER_CPU;
		end else begin
			grant = bus_pkg::MASTER_DBG;
		end
	end

	assign slv_req = (grant == bus_pkg::MASTER_DBG) ? dbg_req : cpu_req;
	assign curr_master = grant;

	// ready only goes back to the master that owns the bus
	always_comb begin
		cpu_rsp.rdata = slv_rsp.rdata;
		cpu_rsp.ready = slv_rsp.ready && (grant == bus_pkg::MASTER_CPU);
		dbg_rsp.rdata = slv_rsp.rdata;
		dbg_rsp.ready = slv_rsp.ready && (grant == bus_pkg::MASTER_DBG);
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			locked <= 1'b0;
			grant_q <= bus_pkg::MASTER_CPU;
		end else if (slv_req.valid && !slv_rsp.ready) begin
			locked <= 1'b1;
			grant_q <= grant;
		end else if (slv_rsp.ready) begin
			locked <= 1'b0;
		end
	end

	// the slave keeps seeing the same request and owner until ready
	a_grant_stable: assert property (@(posedge clk48m) disable iff (rst)
		(slv_req.valid && !slv_rsp.ready) |=>
			($stable(slv_req) && (curr_master == $past(curr_master))))
		else $error("slave request or grant moved while a transfer was pending");

endmodule

//--- hw/dbg_loader.sv
`timescale 1ns/100ps

// debug register port to memory writes
// the port has no back-pressure, so the host must be slower than the bus
module dbg_loader #(
	// must be a power of two
	parameter int DBG_FIFO_DEPTH = 32
) (
	input  logic                clk48m,
	input  logic                rst,
	input  logic                dbgreg_strobe,
	input  logic                dbgreg_sel,
	input  bus_pkg::bus_word_t  dbgreg_in,
	output bus_pkg::bus_req_t   req,
	input  bus_pkg::bus_rsp_t   rsp
);

	localparam int PTR_W = $clog2(DBG_FIFO_DEPTH);

	typedef struct packed {
		logic               sel;
		bus_pkg::bus_word_t data;
	} dbg_entry_t;

	typedef enum logic {
		LD_IDLE,
		LD_WRITE
	} ld_state_t;

	dbg_entry_t fifo_mem [DBG_FIFO_DEPTH];
	dbg_entry_t rd_entry;
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic fifo_empty;
	logic fifo_full;
	ld_state_t state;
	bus_pkg::bus_word_t addr_q;
	bus_pkg::bus_word_t wdata_q;

	// extra pointer bit tells full from empty
	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign rd_entry = fifo_mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk48m) begin
		if (dbgreg_strobe) begin
			fifo_mem[wr_ptr[PTR_W-1:0]] <= '{sel: dbgreg_sel, data: dbgreg_in};
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			state <= LD_IDLE;
			addr_q <= '0;
		end else if (dbgreg_strobe) begin
			// a strobe stalls popping and completion for this cycle
			wr_ptr <= wr_ptr + 1'b1;
		end else if (state == LD_WRITE) begin
			if (rsp.ready) begin
				state <= LD_IDLE;
				addr_q <= addr_q + 32'd4;
			end
		end else if (!fifo_empty) begin
			if (rd_entry.sel) begin
				addr_q <= rd_entry.data;
			end else begin
				wdata_q <= rd_entry.data;
				state <= LD_WRITE;
			end
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// write only master, full word
	assign req = '{valid: (state == LD_WRITE), addr: addr_q, wdata: wdata_q, wstrb: 4'hf};

	a_no_overflow: assert property (@(posedge clk48m) disable iff (rst)
		dbgreg_strobe |-> !fifo_full)
		else $error("debug strobe pushed into a full FIFO");

endmodule

//--- hw/misc_pkg.sv
// misc register map and flash reload constants
package misc_pkg;

	// register index, taken from address bits 5..2
	typedef logic [3:0] misc_reg_t;

	localparam misc_reg_t MISC_LED = 4'd0;
	localparam misc_reg_t MISC_BTN = 4'd1;
	localparam misc_reg_t MISC_SOC_VER = 4'd2;
	localparam misc_reg_t MISC_CPU_NO = 4'd3;
	localparam misc_reg_t MISC_FLASH_SEL = 4'd11;

	typedef logic [15:0] led_t;
	typedef logic [7:0] btn_t;

	// low 24 bits of a flash select write that trigger a reload
	localparam logic [23:0] RELOAD_KEY = 24'hd0f1a5;

	typedef logic [2:0] settle_cnt_t;

	// counter starts at 7, fsel_c is high for counts 5 down to 3
	localparam settle_cnt_t SETTLE_START = 3'd7;
	localparam settle_cnt_t FSEL_C_HI = 3'd5;
	localparam settle_cnt_t FSEL_C_LO = 3'd3;

endpackage

//--- hw/bus_pkg.sv
// shared bus types for both masters, the arbiter and the slaves
package bus_pkg;

	// one data or address word
	typedef logic [31:0] bus_word_t;

	// byte write strobe, all zeros is a read
	typedef logic [3:0] bus_strb_t;

	// top address nibble selects the target
	typedef logic [3:0] region_t;

	// 0 is the CPU, 1 is the debug loader
	typedef logic [0:0] master_idx_t;

	typedef struct packed {
		logic      valid;
		bus_word_t addr;
		bus_word_t wdata;
		bus_strb_t wstrb;
	} bus_req_t;

	typedef struct packed {
		logic      ready;
		bus_word_t rdata;
	} bus_rsp_t;

	localparam region_t REGION_MISC = 4'h2;
	localparam region_t REGION_MEM = 4'h4;

	localparam master_idx_t MASTER_CPU = 1'b0;
	localparam master_idx_t MASTER_DBG = 1'b1;

	// read data seen by a master on an undecoded address
	localparam bus_word_t BUS_ERR_WORD = 32'hdeadbeef;

endpackage
